/* src/csr_pkg.sv */
`default_nettype none

package csr_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] csr_word_t;
    typedef logic [11:0]     csr_addr_t;

    // Machine trap setup and handling
    localparam csr_addr_t CSR_MSTATUS  = 12'h300;
    localparam csr_addr_t CSR_MISA     = 12'h301;
    localparam csr_addr_t CSR_MIE      = 12'h304;
    localparam csr_addr_t CSR_MTVEC    = 12'h305;
    localparam csr_addr_t CSR_MSCRATCH = 12'h340;
    localparam csr_addr_t CSR_MEPC     = 12'h341;
    localparam csr_addr_t CSR_MCAUSE   = 12'h342;
    localparam csr_addr_t CSR_MTVAL    = 12'h343;
    localparam csr_addr_t CSR_MIP      = 12'h344;

    // Counters, machine view and user read-only shadow
    localparam csr_addr_t CSR_MCYCLE   = 12'hB00;
    localparam csr_addr_t CSR_MCYCLEH  = 12'hB80;
    localparam csr_addr_t CSR_CYCLE    = 12'hC00;
    localparam csr_addr_t CSR_CYCLEH   = 12'hC80;

    // MXL = 1, extensions I and M
    localparam csr_word_t MISA_VALUE = 32'h4000_1100;

    localparam csr_word_t CAUSE_ILLEGAL_INST = 32'd2;
    localparam csr_word_t CAUSE_BREAKPOINT   = 32'd3;
    localparam csr_word_t CAUSE_ECALL_U      = 32'd8;
    localparam csr_word_t CAUSE_ECALL_M      = 32'd11;
    localparam csr_word_t CAUSE_MSI          = 32'h8000_0003;
    localparam csr_word_t CAUSE_MTI          = 32'h8000_0007;
    localparam csr_word_t CAUSE_MEI          = 32'h8000_000B;

    // mtvec mode field, values 2 and 3 reserved
    localparam logic [1:0] MTVEC_VECTORED = 2'b01;

    typedef enum logic [1:0] {
        PRIV_USER    = 2'b00,
        PRIV_MACHINE = 2'b11
    } priv_mode_e;

    typedef enum logic [2:0] {
        CMD_NONE   = 3'd0,
        CMD_READ   = 3'd1,
        CMD_WRITE  = 3'd2,
        CMD_SET    = 3'd3,
        CMD_CLEAR  = 3'd4,
        CMD_ECALL  = 3'd5,
        CMD_EBREAK = 3'd6,
        CMD_MRET   = 3'd7
    } csr_cmd_e;

    typedef struct packed {
        logic [18:0] rsv_hi;
        logic [1:0]  mpp;
        logic [2:0]  rsv_mid;
        logic        mpie;
        logic [2:0]  rsv_lo;
        logic        mie;
        logic [2:0]  rsv_low;
    } mstatus_t;

    // Shared by mie and mip
    typedef struct packed {
        logic [19:0] rsv_hi;
        logic        mei;
        logic [2:0]  rsv_ext;
        logic        mti;
        logic [2:0]  rsv_tim;
        logic        msi;
        logic [2:0]  rsv_low;
    } irq_bits_t;

    typedef union packed {
        csr_word_t raw;
        mstatus_t  status;
        irq_bits_t irq;
    } csr_word_u;

    typedef struct packed {
        csr_cmd_e  cmd;
        csr_addr_t addr;
        csr_word_t operand;
        csr_word_t pc;
        csr_word_t inst;
    } csr_req_t;

    typedef struct packed {
        logic      done;
        csr_word_t rdata;
        logic      trap;
        logic      redirect;
        csr_word_t target;
    } csr_resp_t;

    typedef struct packed {
        logic       take_trap;
        logic       do_mret;
        logic       write_en;
        csr_word_t  cause;
        csr_word_t  epc;
        csr_word_t  tval;
        priv_mode_e next_mode;
    } trap_upd_t;

endpackage

`default_nettype wire

/* src/csr_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_regfile #(
    parameter csr_pkg::csr_word_t MTVEC_RESET = '0
) (
    input  wire                   clk,
    input  wire                   arst_n,
    input  wire csr_pkg::csr_addr_t addr,
    input  wire csr_pkg::csr_cmd_e  cmd,
    input  wire csr_pkg::csr_word_t operand,
    input  wire csr_pkg::trap_upd_t upd,
    input  wire                   timer_irq,
    input  wire                   ext_irq,
    output csr_pkg::csr_word_t    rdata,
    output csr_pkg::priv_mode_e   mode,
    output csr_pkg::mstatus_t     mstatus,
    output csr_pkg::irq_bits_t    mie,
    output csr_pkg::irq_bits_t    mip,
    output csr_pkg::csr_word_t    mtvec,
    output csr_pkg::csr_word_t    mepc
);

    import csr_pkg::*;

    csr_word_t   mscratch;
    csr_word_t   mcause;
    csr_word_t   mtval;
    logic        msip_q;
    logic        mtip_q;
    logic        meip_q;
    logic [63:0] cycle;
    csr_word_u   wval;

    // Only MSIP is software writable, the other two mirror the pins
    assign mip = '{mei: meip_q, mti: mtip_q, msi: msip_q, default: '0};

    // Read mux, old values only
    always_comb begin
        case (addr)
            CSR_MSTATUS:  rdata = mstatus;
            CSR_MISA:     rdata = MISA_VALUE;
            CSR_MIE:      rdata = mie;
            CSR_MTVEC:    rdata = mtvec;
            CSR_MSCRATCH: rdata = mscratch;
            CSR_MEPC:     rdata = mepc;
            CSR_MCAUSE:   rdata = mcause;
            CSR_MTVAL:    rdata = mtval;
            CSR_MIP:      rdata = mip;
            CSR_MCYCLE,
            CSR_CYCLE:    rdata = cycle[31:0];
            CSR_MCYCLEH,
            CSR_CYCLEH:   rdata = cycle[63:32];
            default:      rdata = '0;
        endcase
    end

    // New value for write, set and clear
    always_comb begin
        case (cmd)
            CMD_WRITE: wval.raw = operand;
            CMD_SET:   wval.raw = rdata | operand;
            CMD_CLEAR: wval.raw = rdata & ~operand;
            default:   wval.raw = rdata;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode     <= PRIV_MACHINE;
            mstatus  <= '0;
            mie      <= '0;
            mtvec    <= MTVEC_RESET;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
            mtval    <= '0;
            msip_q   <= 1'b0;
        end else if (upd.take_trap) begin
            mode         <= upd.next_mode;
            mepc         <= upd.epc;
            mcause       <= upd.cause;
            // Interrupts leave mtval alone
            if (!upd.cause[XLEN-1]) begin
                mtval <= upd.tval;
            end
            mstatus.mpie <= mstatus.mie;
            mstatus.mie  <= 1'b0;
            mstatus.mpp  <= mode;
        end else if (upd.do_mret) begin
            mode         <= upd.next_mode;
            mstatus.mie  <= mstatus.mpie;
            mstatus.mpie <= 1'b1;
            mstatus.mpp  <= PRIV_USER;
        end else if (upd.write_en) begin
            case (addr)
                CSR_MSTATUS: begin
                    mstatus.mie  <= wval.status.mie;
                    mstatus.mpie <= wval.status.mpie;
                    // Only U and M exist, anything else lands on M
                    mstatus.mpp  <= (wval.status.mpp == PRIV_USER) ? PRIV_USER : PRIV_MACHINE;
                end
                CSR_MIE: begin
                    mie.mei <= wval.irq.mei;
                    mie.mti <= wval.irq.mti;
                    mie.msi <= wval.irq.msi;
                end
                CSR_MIP:      msip_q   <= wval.irq.msi;
                CSR_MTVEC:    mtvec    <= wval.raw;
                CSR_MSCRATCH: mscratch <= wval.raw;
                CSR_MEPC:     mepc     <= {wval.raw[XLEN-1:2], 2'b00};
                CSR_MCAUSE:   mcause   <= wval.raw;
                CSR_MTVAL:    mtval    <= wval.raw;
                default: begin
                end
            endcase
        end
    end

    // Pending mirrors of the interrupt pins
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mtip_q <= 1'b0;
            meip_q <= 1'b0;
        end else begin
            mtip_q <= timer_irq;
            meip_q <= ext_irq;
        end
    end

    // Free running cycle counter, a write replaces one half for that edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cycle <= '0;
        end else if (upd.write_en && addr == CSR_MCYCLE) begin
            cycle <= {cycle[63:32], wval.raw};
        end else if (upd.write_en && addr == CSR_MCYCLEH) begin
            cycle <= {wval.raw, cycle[31:0]};
        end else begin
            cycle <= cycle + 64'd1;
        end
    end

endmodule

`default_nettype wire

/* src/csr_trap_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_trap_ctrl (
    input  wire                    clk,
    input  wire                    arst_n,
    input  wire                    valid,
    input  wire csr_pkg::csr_req_t   req,
    input  wire csr_pkg::csr_word_t  rdata,
    input  wire csr_pkg::priv_mode_e mode,
    input  wire csr_pkg::mstatus_t   mstatus,
    input  wire csr_pkg::irq_bits_t  mie,
    input  wire csr_pkg::irq_bits_t  mip,
    input  wire csr_pkg::csr_word_t  mtvec,
    input  wire csr_pkg::csr_word_t  mepc,
    output csr_pkg::trap_upd_t     upd,
    output csr_pkg::csr_resp_t     resp
);

    import csr_pkg::*;

    logic      is_csr_op;
    logic      is_write_op;
    logic      illegal;
    logic      exc;
    csr_word_t exc_cause;
    csr_word_t exc_tval;
    irq_bits_t pend;
    logic      irq_take;
    csr_word_t irq_cause;
    csr_word_t vec_base;
    csr_word_t trap_target;
    logic      done_q;
    logic      trap_q;
    logic      redirect_q;
    csr_word_t rdata_q;
    csr_word_t target_q;

    assign is_csr_op   = req.cmd inside {CMD_READ, CMD_WRITE, CMD_SET, CMD_CLEAR};
    assign is_write_op = req.cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};

    // Read-only space, privilege level in addr[9:8], MRET from U
    assign illegal = (is_write_op && req.addr[11:10] == 2'b11)
                   || (is_csr_op && req.addr[9:8] > mode)
                   || (req.cmd == CMD_MRET && mode == PRIV_USER);

    assign exc = illegal || req.cmd == CMD_ECALL || req.cmd == CMD_EBREAK;

    always_comb begin
        if (illegal) begin
            exc_cause = CAUSE_ILLEGAL_INST;
            exc_tval  = req.inst;
        end else if (req.cmd == CMD_EBREAK) begin
            exc_cause = CAUSE_BREAKPOINT;
            exc_tval  = req.pc;
        end else begin
            exc_cause = (mode == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
            exc_tval  = '0;
        end
    end

    // Pending and enabled, global enable only matters in M
    assign pend     = irq_bits_t'(mie & mip);
    assign irq_take = !exc && (mode == PRIV_USER || mstatus.mie)
                    && (pend.mei || pend.msi || pend.mti);

    // Fixed order MEI, MSI, MTI
    always_comb begin
        if (pend.mei) begin
            irq_cause = CAUSE_MEI;
        end else if (pend.msi) begin
            irq_cause = CAUSE_MSI;
        end else begin
            irq_cause = CAUSE_MTI;
        end
    end

    assign vec_base = {mtvec[XLEN-1:2], 2'b00};

    always_comb begin
        if (!exc && mtvec[1:0] == MTVEC_VECTORED) begin
            trap_target = vec_base + {irq_cause[XLEN-3:0], 2'b00};
        end else begin
            trap_target = vec_base;
        end
    end

    always_comb begin
        upd.take_trap = valid && (exc || irq_take);
        upd.do_mret   = valid && req.cmd == CMD_MRET && !exc && !irq_take;
        upd.write_en  = valid && is_write_op && !exc && !irq_take;
        upd.cause     = exc ? exc_cause : irq_cause;
        upd.epc       = req.pc;
        upd.tval      = exc_tval;
        upd.next_mode = req.cmd == CMD_MRET && !upd.take_trap
                      ? priv_mode_e'(mstatus.mpp) : PRIV_MACHINE;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_q     <= 1'b0;
            trap_q     <= 1'b0;
            redirect_q <= 1'b0;
        end else begin
            done_q     <= valid;
            trap_q     <= upd.take_trap;
            redirect_q <= upd.take_trap || upd.do_mret;
        end
    end

    always_ff @(posedge clk) begin
        if (valid) begin
            rdata_q  <= rdata;
            target_q <= upd.take_trap ? trap_target : mepc;
        end
    end

    assign resp = '{
        done:     done_q,
        rdata:    rdata_q,
        trap:     trap_q,
        redirect: redirect_q,
        target:   target_q
    };

endmodule

`default_nettype wire

/* src/csr_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit #(
    parameter csr_pkg::csr_word_t MTVEC_RESET = '0
) (
    input  wire                  clk,
    input  wire                  arst_n,
    input  wire                  valid,
    input  wire csr_pkg::csr_req_t req,
    input  wire                  timer_irq,
    input  wire                  ext_irq,
    output csr_pkg::csr_resp_t   resp,
    output csr_pkg::priv_mode_e  mode
);

    import csr_pkg::*;

    trap_upd_t upd;
    csr_word_t rdata;
    mstatus_t  mstatus;
    irq_bits_t mie;
    irq_bits_t mip;
    csr_word_t mtvec;
    csr_word_t mepc;

    // Register state, zero-cycle reads
    csr_regfile #(
        .MTVEC_RESET (MTVEC_RESET)
    ) u_regfile (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (req.addr),
        .cmd       (req.cmd),
        .operand   (req.operand),
        .upd       (upd),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .rdata     (rdata),
        .mode      (mode),
        .mstatus   (mstatus),
        .mie       (mie),
        .mip       (mip),
        .mtvec     (mtvec),
        .mepc      (mepc)
    );

    // Checks, trap selection and the registered response
    csr_trap_ctrl u_trap_ctrl (
        .clk     (clk),
        .arst_n  (arst_n),
        .valid   (valid),
        .req     (req),
        .rdata   (rdata),
        .mode    (mode),
        .mstatus (mstatus),
        .mie     (mie),
        .mip     (mip),
        .mtvec   (mtvec),
        .mepc    (mepc),
        .upd     (upd),
        .resp    (resp)
    );

endmodule

`default_nettype wire

/* test/csr_unit_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_checker (
    input wire                     clk,
    input wire                     arst_n,
    input wire                     valid,
    input wire csr_pkg::csr_resp_t resp
);

    // Fixed latency of one cycle
    a_done_follows_valid: assert property (
        @(posedge clk) disable iff (!arst_n) valid |=> resp.done
    ) else $error("done did not follow valid by one cycle");

    a_trap_redirects: assert property (
        @(posedge clk) disable iff (!arst_n) resp.trap |-> resp.redirect
    ) else $error("trap reported without redirect");

    // No response without a request
    a_done_needs_valid: assert property (
        @(posedge clk) disable iff (!arst_n) resp.done |-> $past(valid)
    ) else $error("done without a valid request the cycle before");

endmodule

bind csr_unit csr_unit_checker u_checker (
    .clk    (clk),
    .arst_n (arst_n),
    .valid  (valid),
    .resp   (resp)
);

`default_nettype wire

/* test/csr_unit_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_unit_tb;

    import csr_pkg::*;

    localparam string STIM_FILE    = "test/csr_unit_input.txt";
    localparam int    DONE_TIMEOUT = 8;

    logic       clk;
    logic       arst_n;
    logic       valid;
    csr_req_t   req;
    logic       timer_irq;
    logic       ext_irq;
    csr_resp_t  resp;
    priv_mode_e mode;

    int         edge_cnt = 0;
    logic [7:0] lfsr;
    logic       have_cycle;
    csr_word_t  first_cycle;
    int         first_edge;

    // Request already sampled by the DUT, response not yet checked
    logic       pend_valid;
    csr_req_t   pend_req;
    csr_word_t  pend_rdata;
    logic       pend_trap;
    logic       pend_red;
    csr_word_t  pend_target;
    priv_mode_e pend_mode;
    int         pend_edge;

    csr_unit UUT (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid     (valid),
        .req       (req),
        .timer_irq (timer_irq),
        .ext_irq   (ext_irq),
        .resp      (resp),
        .mode      (mode)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // One count per clock period on the falling edge
    always @(negedge clk) begin
        edge_cnt++;
    end

    // Galois LFSR with taps for x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 8'hB8;
        end else begin
            return state >> 1;
        end
    endfunction

    // Two LFSR bits give 0 to 3 idle cycles
    function automatic logic [1:0] next_gap();
        logic [1:0] gap;
        for (int i = 0; i < 2; i++) begin
            gap[i] = lfsr[0];
            lfsr   = lfsr_next(lfsr);
        end
        return gap;
    endfunction

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input csr_word_t got, input csr_word_t exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_mode(input string name, input priv_mode_e got, input priv_mode_e exp);
        if (got !== exp) begin
            stop_on_error($sformatf("mismatch %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic drive_request(input csr_req_t r, input logic t_irq, input logic e_irq);
        valid     <= 1'b1;
        req       <= r;
        timer_irq <= t_irq;
        ext_irq   <= e_irq;
    endtask

    task automatic wait_done();
        int cnt;
        cnt = 0;
        @(negedge clk);
        while (!resp.done && cnt < DONE_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (!resp.done) begin
            stop_on_error("response done never came after a request");
        end
    endtask

    task automatic check_response(input csr_req_t r, input csr_word_t e_rdata,
                                  input logic e_trap, input logic e_red,
                                  input csr_word_t e_target, input priv_mode_e e_mode,
                                  input int smp_edge);
        check_flag("trap", resp.trap, e_trap);
        check_flag("redirect", resp.redirect, e_red);
        check_mode("mode", mode, e_mode);
        if (e_red) begin
            check_word("target", resp.target, e_target);
        end
        // Counter reads are checked against the counted edges
        if (r.cmd == CMD_READ && r.addr == CSR_MCYCLE) begin
            if (have_cycle) begin
                check_word("mcycle delta", resp.rdata - first_cycle,
                           csr_word_t'(smp_edge - first_edge));
            end else begin
                have_cycle  = 1'b1;
                first_cycle = resp.rdata;
                first_edge  = smp_edge;
            end
        end else if (r.cmd inside {CMD_READ, CMD_WRITE, CMD_SET, CMD_CLEAR} && !e_trap) begin
            check_word("rdata", resp.rdata, e_rdata);
        end
    endtask

    // Runs up to the falling edge after the edge that sampled the pending request
    task automatic check_pending();
        if (pend_valid) begin
            wait_done();
            check_response(pend_req, pend_rdata, pend_trap, pend_red, pend_target,
                           pend_mode, pend_edge);
            pend_valid = 1'b0;
        end else begin
            @(negedge clk);
        end
    endtask

    initial begin
        int         fd;
        int         status;
        int         n_req;
        string      line;
        csr_req_t   r;
        logic [1:0] gap;
        logic [2:0] f_cmd;
        logic [11:0] f_addr;
        csr_word_t  f_op;
        csr_word_t  f_pc;
        csr_word_t  f_inst;
        logic       f_ti;
        logic       f_ei;
        csr_word_t  e_rdata;
        logic       e_trap;
        logic       e_red;
        csr_word_t  e_target;
        logic [1:0] e_mode;

        arst_n      <= 1'b0;
        valid       <= 1'b0;
        req         <= '0;
        timer_irq   <= 1'b0;
        ext_irq     <= 1'b0;
        lfsr        = 8'd76;
        have_cycle  = 1'b0;
        first_cycle = '0;
        first_edge  = 0;
        pend_valid  = 1'b0;
        n_req       = 0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            stop_on_error("cannot open the stimulus file test/csr_unit_input.txt");
        end else begin
            repeat (2) @(posedge clk);
            arst_n <= 1'b1;
            while (!$feof(fd)) begin
                status = $fgets(line, fd);
                if (status != 0 && $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                        f_cmd, f_addr, f_op, f_pc, f_inst, f_ti, f_ei,
                        e_rdata, e_trap, e_red, e_target, e_mode) == 12) begin
                    r = '{cmd: csr_cmd_e'(f_cmd), addr: f_addr, operand: f_op,
                          pc: f_pc, inst: f_inst};
                    gap = next_gap();
                    if (gap == 0) begin
                        // Back to back with the request sampled on this edge
                        drive_request(r, f_ti, f_ei);
                        check_pending();
                    end else begin
                        valid <= 1'b0;
                        check_pending();
                        repeat (gap) @(posedge clk);
                        drive_request(r, f_ti, f_ei);
                    end
                    // DUT takes the request on this edge
                    @(posedge clk);
                    pend_valid  = 1'b1;
                    pend_req    = r;
                    pend_rdata  = e_rdata;
                    pend_trap   = e_trap;
                    pend_red    = e_red;
                    pend_target = e_target;
                    pend_mode   = priv_mode_e'(e_mode);
                    pend_edge   = edge_cnt;
                    n_req++;
                end
            end
            $fclose(fd);
            valid <= 1'b0;
            check_pending();
            if (n_req == 0) begin
                stop_on_error("no requests were read from the stimulus file");
            end else begin
                $display("NO ERRORS");
                $finish;
            end
        end
    end

endmodule

`default_nettype wire

/* test/csr_unit_input.txt */
# cmd addr operand pc inst timer_irq ext_irq  exp_rdata exp_trap exp_redirect exp_target exp_mode
# all hex; cmd 1 read 2 write 3 set 4 clear 5 ecall 6 ebreak 7 mret; mode 0 user 3 machine
2 340 12345678 00000100 34059073 0 0 00000000 0 0 00000000 3
3 340 000000f0 00000104 3405a073 0 0 12345678 0 0 00000000 3
4 340 00005600 00000108 3405b073 0 0 123456f8 0 0 00000000 3
1 340 00000000 0000010c 34002573 0 0 123400f8 0 0 00000000 3
2 305 00001000 00000110 30559073 0 0 00000000 0 0 00000000 3
3 305 00000200 00000114 3055a073 0 0 00001000 0 0 00000000 3
4 305 00001000 00000118 3055b073 0 0 00001200 0 0 00000000 3
1 305 00000000 0000011c 30502573 0 0 00000200 0 0 00000000 3
1 b00 00000000 00000120 b0002573 0 0 00000000 0 0 00000000 3
2 341 00000803 00000124 34159073 0 0 00000000 0 0 00000000 3
1 341 00000000 00000128 34102573 0 0 00000800 0 0 00000000 3
7 000 00000000 0000012c 30200073 0 0 00000000 0 1 00000800 0
2 340 0000abcd 00000900 34069073 0 0 00000000 1 1 00000200 3
1 342 00000000 00000130 34202573 0 0 00000002 0 0 00000000 3
7 000 00000000 00000134 30200073 0 0 00000000 0 1 00000900 0
2 b00 00000000 00000a00 b0001073 0 0 00000000 1 1 00000200 3
1 342 00000000 00000138 34202573 0 0 00000002 0 0 00000000 3
7 000 00000000 0000013c 30200073 0 0 00000000 0 1 00000a00 0
5 000 00000000 00000b00 00000073 0 0 00000000 1 1 00000200 3
1 342 00000000 00000140 34202573 0 0 00000008 0 0 00000000 3
6 000 00000000 00000c00 00100073 0 0 00000000 1 1 00000200 3
1 342 00000000 00000144 34202573 0 0 00000003 0 0 00000000 3
7 000 00000000 00000148 30200073 0 0 00000000 0 1 00000c00 3
2 304 00000880 0000014c 30479073 0 0 00000000 0 0 00000000 3
2 305 00000201 00000150 30559073 0 0 00000200 0 0 00000000 3
3 300 00000008 00000154 3004a073 0 0 00000080 0 0 00000000 3
1 340 00000000 00000158 34002573 1 1 123400f8 0 0 00000000 3
1 340 00000000 00000d00 34002573 1 1 00000000 1 1 0000022c 3
7 000 00000000 0000015c 30200073 1 0 00000000 0 1 00000d00 3
1 340 00000000 00000e00 34002573 1 0 00000000 1 1 0000021c 3
1 340 00000000 00000160 34002573 1 1 123400f8 0 0 00000000 3
1 342 00000000 00000164 34202573 1 1 80000007 0 0 00000000 3
1 b00 00000000 00000168 b0002573 0 0 00000000 0 0 00000000 3

/* src.f */
src/csr_pkg.sv
src/csr_regfile.sv
src/csr_trap_ctrl.sv
src/csr_unit.sv
test/csr_unit_checker.sv
test/csr_unit_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = csr_unit_tb
FILELIST  = src.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(filter %.sv,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: run

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
